//--- logic/lru_macros.svh
/*
  Size defines for the pseudo-LRU tracker.
  LRU_N_ENTRIES must be a power of two, since the set index is sliced
  straight from a counter. LRU_N_WAYS must be at least 2.
*/

`ifndef LRU_MACROS_SVH
`define LRU_MACROS_SVH

// Number of ways tracked in each set
`define LRU_N_WAYS 4

// Number of sets, one age vector per set
`define LRU_N_ENTRIES 64

`endif

//--- logic/lru_pkg.sv
/*
  Types and the merge rule shared by the pseudo-LRU tracker.
  All widths follow the defines in the macro header, so every block
  that imports this package agrees on the set and way sizes.
*/

`default_nettype none

`include "lru_macros.svh"

package lru_pkg;

    // Set index into the age RAM
    typedef logic [$clog2(`LRU_N_ENTRIES)-1:0] t_entry_idx;

    // One bit per way, used both for references and for stored ages
    typedef logic [`LRU_N_WAYS-1:0] t_way_vec;

    // Way number, as returned by a lookup
    typedef logic [$clog2(`LRU_N_WAYS)-1:0] t_way_idx;

    // Each reference port is either waiting or writing back its merge
    typedef enum logic
    {
        PORT_IDLE  = 1'b0,
        PORT_WRITE = 1'b1
    } t_port_state;

    // OR the new references into the stored vector
    // A vector that would become all ones starts over from zero
    function automatic t_way_vec lru_merge(input t_way_vec cur, input t_way_vec new_ref);
        t_way_vec upd;
        upd = cur | new_ref;
        return (&upd) ? '0 : upd;
    endfunction

endpackage

`default_nettype wire

//--- logic/lru_sweep_counter.sv
/*
  Walks every set index once after reset so the age RAM can be cleared.
  sweep_done rises after LRU_N_ENTRIES clocks with reset released and
  stays high until the next reset.
*/

`timescale 1ns/1ns
`default_nettype none

module lru_sweep_counter
(
    input  logic                clk,
    input  logic                reset_n,
    output lru_pkg::t_entry_idx sweep_idx,
    output logic                sweep_done
);
    import lru_pkg::*;

    // One extra bit on top of the index, it becomes the done flag
    logic [$bits(t_entry_idx):0] count;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            count <= '0;
        end
        else if (!count[$bits(t_entry_idx)])
        begin
            count <= count + 1'b1;
        end
    end

    // Low bits name the set being cleared in this cycle
    assign sweep_idx  = count[$bits(t_entry_idx)-1:0];
    assign sweep_done = count[$bits(t_entry_idx)];

endmodule

`default_nettype wire

//--- logic/lru_update_fsm.sv
/*
  Read-modify-write sequencing for both reference ports.
  References are sampled, never queued. A reference that arrives while
  its port is writing is dropped. On port 1 a lookup wins over both a new
  reference and a pending write, and a port 1 write to the set that port 0
  writes in the same cycle is dropped. Nothing is captured before the
  sweep ends.
*/

`timescale 1ns/1ns
`default_nettype none

module lru_update_fsm
(
    input  logic                clk,
    input  logic                reset_n,

    input  lru_pkg::t_entry_idx sweep_idx,
    input  logic                sweep_done,

    input  lru_pkg::t_entry_idx lookup_idx,
    input  logic                lookup_en,

    input  lru_pkg::t_entry_idx ref_idx0,
    input  lru_pkg::t_way_vec   ref_way_vec0,
    input  logic                ref_en0,

    input  lru_pkg::t_entry_idx ref_idx1,
    input  lru_pkg::t_way_vec   ref_way_vec1,
    input  logic                ref_en1,

    input  lru_pkg::t_way_vec   rdata0,
    input  lru_pkg::t_way_vec   rdata1,

    output lru_pkg::t_entry_idx addr0,
    output logic                wen0,
    output lru_pkg::t_way_vec   wdata0,

    output lru_pkg::t_entry_idx addr1,
    output logic                wen1,
    output lru_pkg::t_way_vec   wdata1
);
    import lru_pkg::*;

    t_port_state state0;
    t_port_state state1;

    // Reference held for the write cycle that follows its read
    t_entry_idx  cap_idx0;
    t_way_vec    cap_vec0;
    t_entry_idx  cap_idx1;
    t_way_vec    cap_vec1;

    logic        start0;
    logic        start1;

    // A reference is taken only by an idle port once the RAM is cleared
    assign start0 = ref_en0 && sweep_done && (state0 == PORT_IDLE);

    // Port 1 also shares its RAM port with lookups, which have priority
    assign start1 = ref_en1 && !lookup_en && sweep_done && (state1 == PORT_IDLE);

    // ==============================
    // Port state and capture
    // ==============================

    // A write cycle always falls back to idle, even if port 1 was cancelled
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state0 <= PORT_IDLE;
            state1 <= PORT_IDLE;
        end
        else
        begin
            state0 <= start0 ? PORT_WRITE : PORT_IDLE;
            state1 <= start1 ? PORT_WRITE : PORT_IDLE;
        end
    end

    always_ff @(posedge clk)
    begin
        if (start0)
        begin
            cap_idx0 <= ref_idx0;
            cap_vec0 <= ref_way_vec0;
        end
        if (start1)
        begin
            cap_idx1 <= ref_idx1;
            cap_vec1 <= ref_way_vec1;
        end
    end

    // ==============================
    // RAM port 0
    // ==============================

    // Sweep first, then the pending write, otherwise read for a new reference
    always_comb
    begin
        if (!sweep_done)
        begin
            addr0  = sweep_idx;
            wdata0 = '0;
            wen0   = 1'b1;
        end
        else if (state0 == PORT_WRITE)
        begin
            addr0  = cap_idx0;
            wdata0 = lru_merge(rdata0, cap_vec0);
            wen0   = 1'b1;
        end
        else
        begin
            addr0  = ref_idx0;
            wdata0 = '0;
            wen0   = 1'b0;
        end
    end

    // ==============================
    // RAM port 1
    // ==============================

    // The lookup address wins, so a lookup in a write cycle sees old data
    always_comb
    begin
        wdata1 = lru_merge(rdata1, cap_vec1);
        if (lookup_en)
        begin
            addr1 = lookup_idx;
        end
        else if (state1 == PORT_WRITE)
        begin
            addr1 = cap_idx1;
        end
        else
        begin
            addr1 = ref_idx1;
        end
    end

    // Port 0 keeps its update when both ports land on one set
    assign wen1 = (state1 == PORT_WRITE) && !lookup_en
                  && !(wen0 && (addr0 == cap_idx1));

    // A port 1 write goes back to the set that port 1 read one cycle before
    a_port1_rmw_addr: assert property (@(posedge clk) disable iff (!reset_n)
        wen1 |-> (addr1 == $past(addr1)));

    // The conflict rule keeps the two write ports apart
    a_no_double_write: assert property (@(posedge clk) disable iff (!reset_n)
        (wen0 && wen1) |-> (addr0 != addr1));

    // No reference may reach the write cycle while the sweep still owns port 0
    a_no_write_in_sweep: assert property (@(posedge clk) disable iff (!reset_n)
        !sweep_done |-> ((state0 == PORT_IDLE) && (state1 == PORT_IDLE)));

endmodule

`default_nettype wire

//--- logic/lru_dualport_ram.sv
/*
  Two-port synchronous RAM on one clock, no reset on the array.
  A read returns the data held before a write in the same cycle.
  The two ports must never write one address in the same cycle.
*/

`timescale 1ns/1ns
`default_nettype none

module lru_dualport_ram
#(
    parameter int N_ENTRIES   = 64,
    parameter int N_DATA_BITS = 4
)
(
    input  logic                         clk,

    input  logic [$clog2(N_ENTRIES)-1:0] addr0,
    input  logic                         wen0,
    input  logic [N_DATA_BITS-1:0]       wdata0,
    output logic [N_DATA_BITS-1:0]       rdata0,

    input  logic [$clog2(N_ENTRIES)-1:0] addr1,
    input  logic                         wen1,
    input  logic [N_DATA_BITS-1:0]       wdata1,
    output logic [N_DATA_BITS-1:0]       rdata1
);

    logic [N_DATA_BITS-1:0] mem [N_ENTRIES];

    // Reads sample the array before this edge's writes land
    always_ff @(posedge clk)
    begin
        if (wen0)
        begin
            mem[addr0] <= wdata0;
        end
        if (wen1)
        begin
            mem[addr1] <= wdata1;
        end
        rdata0 <= mem[addr0];
        rdata1 <= mem[addr1];
    end

    // Two writes to one word would leave its content undefined
    a_write_collision: assert property (@(posedge clk)
        (wen0 && wen1) |-> (addr0 != addr1));

endmodule

`default_nettype wire

//--- logic/lru_victim_encode.sv
/*
  Picks the victim from an age vector, the lowest way whose bit is clear.
  The answer comes as a one-hot vector and as a way number.
  A vector with no clear bit gives zero on both outputs.
*/

`timescale 1ns/1ns
`default_nettype none

module lru_victim_encode
(
    input  lru_pkg::t_way_vec age_vec,
    output lru_pkg::t_way_vec victim_vec,
    output lru_pkg::t_way_idx victim_idx
);
    import lru_pkg::*;

    logic found;

    // Scan upward from way 0 and stop at the first clear bit
    always_comb
    begin
        found      = 1'b0;
        victim_vec = '0;
        victim_idx = '0;
        for (int w = 0; w < $bits(t_way_vec); w++)
        begin
            if (!found && !age_vec[w])
            begin
                found         = 1'b1;
                victim_vec[w] = 1'b1;
                victim_idx    = t_way_idx'(w);
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/lru_pseudo.sv
/*
  Pseudo-LRU tracker, one age bit per way in each set.
  A lookup is answered in the cycle after lookup_en, and only then.
  References are best effort, some are dropped on conflicts, and none
  is taken before rdy. rdy rises once the RAM clear after reset ends.
*/

`timescale 1ns/1ns
`default_nettype none

`include "lru_macros.svh"

module lru_pseudo
(
    input  logic                clk,
    input  logic                reset_n,

    // High once initialization is over, then stays high
    output logic                rdy,

    input  lru_pkg::t_entry_idx lookup_idx,
    input  logic                lookup_en,

    // Victim for the set looked up in the previous cycle
    output lru_pkg::t_way_vec   lookup_vec_rsp,
    output lru_pkg::t_way_idx   lookup_rsp,

    // Reference port 0, ORed into the stored vector
    input  lru_pkg::t_entry_idx ref_idx0,
    input  lru_pkg::t_way_vec   ref_way_vec0,
    input  logic                ref_en0,

    // Reference port 1, yields to lookups
    input  lru_pkg::t_entry_idx ref_idx1,
    input  lru_pkg::t_way_vec   ref_way_vec1,
    input  logic                ref_en1
);
    import lru_pkg::*;

    t_entry_idx sweep_idx;
    logic       sweep_done;

    t_entry_idx addr0;
    logic       wen0;
    t_way_vec   wdata0;
    t_way_vec   rdata0;

    t_entry_idx addr1;
    logic       wen1;
    t_way_vec   wdata1;
    t_way_vec   rdata1;

    // ==============================
    // Initialization
    // ==============================

    lru_sweep_counter sweep_i
    (
        .clk        (clk),
        .reset_n    (reset_n),
        .sweep_idx  (sweep_idx),
        .sweep_done (sweep_done)
    );

    assign rdy = sweep_done;

    // ==============================
    // Port control and storage
    // ==============================

    lru_update_fsm fsm_i
    (
        .clk          (clk),
        .reset_n      (reset_n),
        .sweep_idx    (sweep_idx),
        .sweep_done   (sweep_done),
        .lookup_idx   (lookup_idx),
        .lookup_en    (lookup_en),
        .ref_idx0     (ref_idx0),
        .ref_way_vec0 (ref_way_vec0),
        .ref_en0      (ref_en0),
        .ref_idx1     (ref_idx1),
        .ref_way_vec1 (ref_way_vec1),
        .ref_en1      (ref_en1),
        .rdata0       (rdata0),
        .rdata1       (rdata1),
        .addr0        (addr0),
        .wen0         (wen0),
        .wdata0       (wdata0),
        .addr1        (addr1),
        .wen1         (wen1),
        .wdata1       (wdata1)
    );

    lru_dualport_ram
    #(
        .N_ENTRIES   (`LRU_N_ENTRIES),
        .N_DATA_BITS (`LRU_N_WAYS)
    )
    ram_i
    (
        .clk    (clk),
        .addr0  (addr0),
        .wen0   (wen0),
        .wdata0 (wdata0),
        .rdata0 (rdata0),
        .addr1  (addr1),
        .wen1   (wen1),
        .wdata1 (wdata1),
        .rdata1 (rdata1)
    );

    // Port 1 read data is the lookup answer in the cycle after lookup_en
    lru_victim_encode victim_i
    (
        .age_vec    (rdata1),
        .victim_vec (lookup_vec_rsp),
        .victim_idx (lookup_rsp)
    );

endmodule

`default_nettype wire

//--- test/lru_pseudo_tb.sv
/*
  Testbench for the pseudo-LRU tracker.
  Inputs change 2 ns after each rising edge, lookup answers are checked at
  the falling edge of the answer cycle against a cycle model of the rules.
  Directed sets assume at least 4 ways and 64 sets.
*/

`timescale 1ns/1ns
`default_nettype none

`include "lru_macros.svh"

module lru_pseudo_tb;
    import lru_pkg::*;

    localparam int N_SETS       = `LRU_N_ENTRIES;
    localparam int N_WAYS       = `LRU_N_WAYS;
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 16;
    localparam int RAND_CYCLES  = 3000;
    // Lookup sweep, directed tests and random mix, in clock cycles
    localparam int TEST_CYCLES  = 2 * N_SETS + 12 * N_WAYS + 120 + RAND_CYCLES;
    localparam int WDOG_CYCLES  = RESET_CYCLES + 3 * N_SETS + TEST_CYCLES + 300;

    logic       clk;
    logic       reset_n;
    logic       rdy;
    t_entry_idx lookup_idx;
    logic       lookup_en;
    t_way_vec   lookup_vec_rsp;
    t_way_idx   lookup_rsp;
    t_entry_idx ref_idx0;
    t_way_vec   ref_way_vec0;
    logic       ref_en0;
    t_entry_idx ref_idx1;
    t_way_vec   ref_way_vec1;
    logic       ref_en1;

    // Model of the stored vectors and of both reference ports
    t_way_vec   model_mem [N_SETS];
    logic       m_write0;
    logic       m_write1;
    t_entry_idx m_idx0;
    t_entry_idx m_idx1;
    t_way_vec   m_vec0;
    t_way_vec   m_vec1;
    t_way_vec   m_rd0;
    t_way_vec   m_rd1;
    int         ready_cnt;

    // Expected answer for the lookup sampled at the last edge
    logic       chk_valid;
    t_entry_idx chk_set;
    t_way_vec   exp_vec;
    t_way_idx   exp_idx;

    int         cmp_checks;
    int         cmp_errors;
    int         stim_checks;
    int         stim_errors;

    lru_pseudo lru_pseudo_i
    (
        .clk            (clk),
        .reset_n        (reset_n),
        .rdy            (rdy),
        .lookup_idx     (lookup_idx),
        .lookup_en      (lookup_en),
        .lookup_vec_rsp (lookup_vec_rsp),
        .lookup_rsp     (lookup_rsp),
        .ref_idx0       (ref_idx0),
        .ref_way_vec0   (ref_way_vec0),
        .ref_en0        (ref_en0),
        .ref_idx1       (ref_idx1),
        .ref_way_vec1   (ref_way_vec1),
        .ref_en1        (ref_en1)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ==============================
    // Reference model
    // ==============================

    // New references are ORed in, a full vector wraps back to all zero
    function automatic t_way_vec model_merge(input t_way_vec cur, input t_way_vec new_ref);
        t_way_vec res;
        res = cur | new_ref;
        if (res == {N_WAYS{1'b1}})
        begin
            res = '0;
        end
        return res;
    endfunction

    // Lowest clear way, found by scanning down so the last hit wins
    function automatic t_way_idx expected_victim_idx(input t_way_vec vec);
        t_way_idx idx;
        idx = '0;
        for (int w = N_WAYS - 1; w >= 0; w--)
        begin
            if (!vec[w])
            begin
                idx = t_way_idx'(w);
            end
        end
        return idx;
    endfunction

    // One clock edge of the tracker. All reads see the vectors before this edge
    function void model_cycle();
        logic       ready;
        logic       start0;
        logic       start1;
        logic       do_wr0;
        logic       do_wr1;
        t_way_vec   wr_val0;
        t_way_vec   wr_val1;
        ready     = (ready_cnt >= N_SETS);
        chk_valid = lookup_en && ready;
        if (lookup_en)
        begin
            chk_set = lookup_idx;
            exp_idx = expected_victim_idx(model_mem[lookup_idx]);
            exp_vec = t_way_vec'(1) << exp_idx;
        end
        // Write cycles merge the data read when the reference was captured
        do_wr0  = m_write0;
        wr_val0 = model_merge(m_rd0, m_vec0);
        do_wr1  = m_write1 && !lookup_en && !(do_wr0 && (m_idx0 == m_idx1));
        wr_val1 = model_merge(m_rd1, m_vec1);
        // A busy port drops its reference, and port 1 yields to a lookup
        start0 = ref_en0 && ready && !m_write0;
        start1 = ref_en1 && !lookup_en && ready && !m_write1;
        // Captures read the vectors as they were before this edge's writes
        if (start0)
        begin
            m_rd0  = model_mem[ref_idx0];
            m_idx0 = ref_idx0;
            m_vec0 = ref_way_vec0;
        end
        if (start1)
        begin
            m_rd1  = model_mem[ref_idx1];
            m_idx1 = ref_idx1;
            m_vec1 = ref_way_vec1;
        end
        if (do_wr0)
        begin
            model_mem[m_idx0] = wr_val0;
        end
        if (do_wr1)
        begin
            model_mem[m_idx1] = wr_val1;
        end
        m_write0 = start0;
        m_write1 = start1;
        if (ready_cnt < N_SETS)
        begin
            ready_cnt++;
        end
    endfunction

    always @(posedge clk)
    begin
        if (!reset_n)
        begin
            for (int s = 0; s < N_SETS; s++)
            begin
                model_mem[s] = '0;
            end
            m_write0  = 1'b0;
            m_write1  = 1'b0;
            ready_cnt = 0;
            chk_valid = 1'b0;
        end
        else
        begin
            model_cycle();
        end
    end

    // ==============================
    // Compare
    // ==============================

    task automatic check_vec(input t_way_vec got, input t_way_vec want, input t_entry_idx set);
        cmp_checks++;
        if (got !== want)
        begin
            cmp_errors++;
            $display("Error at %0t ns: set %0d victim vector %b, expected %b",
                     $time, set, got, want);
        end
    endtask

    task automatic check_idx(input t_way_idx got, input t_way_idx want, input t_entry_idx set);
        cmp_checks++;
        if (got !== want)
        begin
            cmp_errors++;
            $display("Error at %0t ns: set %0d victim way %0d, expected %0d",
                     $time, set, got, want);
        end
    endtask

    // Answers are stable by the falling edge of the cycle after lookup_en
    always @(negedge clk)
    begin
        if (chk_valid)
        begin
            check_vec(lookup_vec_rsp, exp_vec, chk_set);
            check_idx(lookup_rsp, exp_idx, chk_set);
        end
        if (reset_n && (ready_cnt >= N_SETS) && (rdy !== 1'b1))
        begin
            cmp_errors++;
            $display("Error at %0t ns: rdy is low after initialization", $time);
        end
    end

    // ==============================
    // Stimulus
    // ==============================

    task automatic idle_cycles(input int n);
        repeat (n)
        begin
            @(posedge clk);
            #2;
        end
    endtask

    // Hold one cycle of inputs, then leave all enables low
    task automatic drive_cycle(input logic l_en, input t_entry_idx l_idx,
                               input logic e0, input t_entry_idx i0, input t_way_vec v0,
                               input logic e1, input t_entry_idx i1, input t_way_vec v1);
        lookup_en    = l_en;
        lookup_idx   = l_idx;
        ref_en0      = e0;
        ref_idx0     = i0;
        ref_way_vec0 = v0;
        ref_en1      = e1;
        ref_idx1     = i1;
        ref_way_vec1 = v1;
        @(posedge clk);
        #2;
        lookup_en = 1'b0;
        ref_en0   = 1'b0;
        ref_en1   = 1'b0;
    endtask

    task automatic lookup_set(input t_entry_idx set);
        drive_cycle(1'b1, set, 1'b0, '0, '0, 1'b0, '0, '0);
        idle_cycles(1);
    endtask

    // One reference on its own, then a lookup once the write has landed
    task automatic ref_then_lookup(input int port, input t_entry_idx set, input int way);
        if (port == 0)
        begin
            drive_cycle(1'b0, '0, 1'b1, set, t_way_vec'(1 << way), 1'b0, '0, '0);
        end
        else
        begin
            drive_cycle(1'b0, '0, 1'b0, '0, '0, 1'b1, set, t_way_vec'(1 << way));
        end
        idle_cycles(2);
        lookup_set(set);
    endtask

    task automatic report_test(input string name, input int chk_start, input int err_start);
        int chk;
        int err;
        chk = cmp_checks + stim_checks - chk_start;
        err = cmp_errors + stim_errors - err_start;
        $display("%-30s %0d checks, %0d errors, %s", name, chk, err, (err == 0) ? "pass" : "fail");
    endtask

    initial
    begin
        int cnt;
        int chk0;
        int err0;
        void'($urandom(32'haaef7b06));
        cmp_checks  = 0;
        cmp_errors  = 0;
        stim_checks = 0;
        stim_errors = 0;
        reset_n     = 1'b0;
        lookup_en   = 1'b0;
        lookup_idx  = '0;
        ref_en0     = 1'b0;
        ref_idx0    = '0;
        ref_way_vec0 = '0;
        ref_en1     = 1'b0;
        ref_idx1    = '0;
        ref_way_vec1 = '0;
        idle_cycles(RESET_CYCLES);

        // Test 1: rdy timing, then every set starts with way 0 as victim
        chk0 = 0;
        err0 = 0;
        stim_checks++;
        if (rdy !== 1'b0)
        begin
            stim_errors++;
            $display("Error at %0t ns: rdy is high during reset", $time);
        end
        reset_n = 1'b1;
        cnt = 0;
        while ((rdy !== 1'b1) && (cnt <= 2 * N_SETS))
        begin
            idle_cycles(1);
            cnt++;
        end
        stim_checks++;
        if (rdy !== 1'b1)
        begin
            stim_errors++;
            $display("rdy never rose within %0d cycles of reset release", 2 * N_SETS);
        end
        else
        begin
            if (cnt != N_SETS)
            begin
                stim_errors++;
                $display("Error at %0t ns: rdy rose %0d cycles after reset, expected %0d",
                         $time, cnt, N_SETS);
            end
            for (int s = 0; s < N_SETS; s++)
            begin
                drive_cycle(1'b1, t_entry_idx'(s), 1'b0, '0, '0, 1'b0, '0, '0);
            end
            idle_cycles(2);
            report_test("1 reset and initial lookups", chk0, err0);

            // Test 2: alternate ports until the set wraps, then again with the ports swapped
            chk0 = cmp_checks + stim_checks;
            err0 = cmp_errors + stim_errors;
            for (int w = 0; w < N_WAYS; w++)
            begin
                ref_then_lookup(w % 2, t_entry_idx'(5), w);
            end
            for (int w = 0; w < N_WAYS; w++)
            begin
                ref_then_lookup((w + 1) % 2, t_entry_idx'(9), w);
            end
            report_test("2 single references", chk0, err0);

            // Test 3: the reference in each write cycle is lost
            chk0 = cmp_checks + stim_checks;
            err0 = cmp_errors + stim_errors;
            drive_cycle(1'b0, '0, 1'b1, t_entry_idx'(12), t_way_vec'(1), 1'b0, '0, '0);
            drive_cycle(1'b0, '0, 1'b1, t_entry_idx'(12), t_way_vec'(2), 1'b0, '0, '0);
            idle_cycles(2);
            lookup_set(t_entry_idx'(12));
            for (int w = 0; w < 3; w++)
            begin
                drive_cycle(1'b0, '0, 1'b0, '0, '0, 1'b1, t_entry_idx'(13), t_way_vec'(1 << w));
            end
            idle_cycles(2);
            lookup_set(t_entry_idx'(13));
            report_test("3 back-to-back references", chk0, err0);

            // Test 4: a lookup blocks a port 1 capture and cancels its write
            chk0 = cmp_checks + stim_checks;
            err0 = cmp_errors + stim_errors;
            drive_cycle(1'b1, t_entry_idx'(21), 1'b0, '0, '0, 1'b1, t_entry_idx'(20), 1);
            idle_cycles(2);
            lookup_set(t_entry_idx'(20));
            drive_cycle(1'b0, '0, 1'b0, '0, '0, 1'b1, t_entry_idx'(20), t_way_vec'(1));
            drive_cycle(1'b1, t_entry_idx'(22), 1'b0, '0, '0, 1'b0, '0, '0);
            idle_cycles(2);
            lookup_set(t_entry_idx'(20));
            ref_then_lookup(1, t_entry_idx'(20), 0);
            report_test("4 lookup priority", chk0, err0);

            // Test 5: same set on both ports keeps port 0, distinct sets keep both
            chk0 = cmp_checks + stim_checks;
            err0 = cmp_errors + stim_errors;
            drive_cycle(1'b0, '0, 1'b1, t_entry_idx'(30), t_way_vec'(1),
                        1'b1, t_entry_idx'(30), t_way_vec'(2));
            idle_cycles(2);
            lookup_set(t_entry_idx'(30));
            drive_cycle(1'b0, '0, 1'b1, t_entry_idx'(31), t_way_vec'(1),
                        1'b1, t_entry_idx'(32), t_way_vec'(1));
            idle_cycles(2);
            lookup_set(t_entry_idx'(31));
            lookup_set(t_entry_idx'(32));
            report_test("5 same-set write conflict", chk0, err0);

            // Test 6: few sets, so collisions and drops happen often
            chk0 = cmp_checks + stim_checks;
            err0 = cmp_errors + stim_errors;
            for (int i = 0; i < RAND_CYCLES; i++)
            begin
                drive_cycle(($urandom % 3) == 0, t_entry_idx'($urandom % 8),
                            ($urandom % 2) == 0, t_entry_idx'($urandom % 8), t_way_vec'($urandom),
                            ($urandom % 2) == 0, t_entry_idx'($urandom % 8), t_way_vec'($urandom));
            end
            idle_cycles(2);
            report_test("6 random mix", chk0, err0);
        end

        $display("total: %0d checks, %0d errors", cmp_checks + stim_checks,
                 cmp_errors + stim_errors);
        if ((cmp_errors + stim_errors) == 0)
        begin
            $display("*** TEST PASSED ***");
        end
        else
        begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Upper bound on the whole run, reset and sweep included
    initial
    begin
        #(WDOG_CYCLES * CLK_PERIOD);
        $display("Simulation did not finish within %0d clock cycles", WDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+logic
logic/lru_pkg.sv
logic/lru_sweep_counter.sv
logic/lru_update_fsm.sv
logic/lru_dualport_ram.sv
logic/lru_victim_encode.sv
logic/lru_pseudo.sv
test/lru_pseudo_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the pseudo-LRU testbench with Verilator and runs it.
# Exits non-zero if the build fails, the run fails, or the pass line is missing.

set -u

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG_FILE=sim.log
SIM_BIN=lru_pseudo_sim

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f build.f --top-module lru_pseudo_tb \
    -Mdir "$OBJ_DIR" -o "$SIM_BIN"
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$OBJ_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qF "*** TEST PASSED ***" "$LOG_FILE"; then
    echo "Result: pass"
    exit 0
else
    echo "Result: fail, see $LOG_FILE"
    exit 1
fi
